//--- hw/ctrlPkg.sv
package ctrlPkg;

	// ****************************************
	// widths
	// ****************************************
	typedef logic [31:0] instr_t;
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;
	typedef logic [2:0] aluOp_t;
	typedef logic [3:0] immSel_t;
	typedef logic [3:0] muxSel_t;

	// ****************************************
	// instruction encodings
	// ****************************************
	localparam opcode_t opcodeReg = 7'b0110011;
	localparam opcode_t opcodeImm = 7'b0010011;
	localparam opcode_t opcodeBranch = 7'b1100011;
	localparam opcode_t opcodeLui = 7'b0110111;
	localparam opcode_t opcodeLoad = 7'b0000011;
	localparam opcode_t opcodeStore = 7'b0100011;
	localparam opcode_t opcodeJal = 7'b1101111;
	localparam opcode_t opcodeJalr = 7'b1100111;
	localparam opcode_t opcodeSystem = 7'b1110011;

	localparam funct3_t f3AddSub = 3'b000;	// also jalr and ebreak
	localparam funct3_t f3Slt = 3'b010;
	localparam funct3_t f3And = 3'b111;
	localparam funct3_t f3Double = 3'b011;	// ld / sd
	localparam funct3_t f3Beq = 3'b000;
	localparam funct3_t f3Bne = 3'b001;
	localparam funct3_t f3Blt = 3'b100;
	localparam funct3_t f3Bge = 3'b101;

	localparam funct7_t funct7Base = 7'b0000000;
	localparam funct7_t funct7Sub = 7'b0100000;

	// ****************************************
	// datapath control codes
	// ****************************************
	localparam aluOp_t aluAdd = 3'd1;
	localparam aluOp_t aluSub = 3'd2;
	localparam aluOp_t aluAnd = 3'd3;
	localparam aluOp_t aluCompare = 3'd6;	// sets equal/less flags

	localparam immSel_t immNone = 4'd0;
	localparam immSel_t immI = 4'd1;
	localparam immSel_t immB = 4'd2;
	localparam immSel_t immU = 4'd3;
	localparam immSel_t immS = 4'd4;
	localparam immSel_t immJ = 4'd5;

	localparam muxSel_t srcAPc = 4'd0;
	localparam muxSel_t srcARegA = 4'd1;
	localparam muxSel_t srcAZero = 4'd2;	// lui passes the immediate through
	localparam muxSel_t srcBFour = 4'd0;
	localparam muxSel_t srcBRegB = 4'd1;
	localparam muxSel_t srcBImm = 4'd2;
	localparam muxSel_t wbAluOut = 4'd0;
	localparam muxSel_t wbMem = 4'd1;
	localparam muxSel_t wbPc = 4'd2;
	localparam muxSel_t wbLessZero = 4'd5;
	localparam muxSel_t wbLessOne = 4'd6;
	localparam muxSel_t pcAlu = 4'd0;
	localparam muxSel_t pcAluOut = 4'd1;
	localparam muxSel_t pcIllegalVec = 4'd2;
	localparam muxSel_t pcOverflowVec = 4'd3;
	localparam muxSel_t pcCauseVec = 4'd4;	// handler address from MDR
	localparam muxSel_t mem64AddrAlu = 4'd0;
	localparam muxSel_t mem64AddrOut = 4'd1;

	typedef enum logic [3:0] {
		clsArith, clsArithNoOvf, clsSetLess, clsBranch, clsLui, clsLoad,
		clsStore, clsJal, clsJalr, clsBreak, clsIllegal
	} opClass_e;

	typedef enum logic [4:0] {
		stepReset, stepFetch, stepDispatch, stepExecute, stepWriteback,
		stepSetLess, stepCompare, stepTakeBranch, stepAddress, stepLoadWait,
		stepLoadWrite, stepMemWrite, stepLinkJump, stepJalrTarget, stepJalrJump,
		stepHalt, stepIllegalTrap, stepOverflowTrap, stepCauseLoad, stepTrapJump
	} ctrlStep_e;

endpackage

//--- hw/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf (
	input logic clk
);
	import ctrlPkg::*;

	opClass_e opClass;	// operation class of the held instruction
	aluOp_t aluOp;
	immSel_t immSel;
	funct3_t branchCond;	// raw funct3, only meaningful for branches

	modport decoder (
		output opClass, aluOp, immSel, branchCond
	);
	modport sequencer (
		input opClass, branchCond
	);
	modport encoder (
		input clk, opClass, aluOp, immSel
	);

endinterface

//--- hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
	input ctrlPkg::instr_t instr,
	decodeIf.decoder dec
);
	import ctrlPkg::*;

	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign dec.branchCond = funct3;	// sequencer evaluates it

	always_comb
	begin
		dec.opClass = clsIllegal;	// anything unmatched traps
		dec.aluOp = aluAdd;
		dec.immSel = immNone;
		case (opcode)
			opcodeReg:
			begin
				if (funct7 == funct7Base && funct3 == f3AddSub)
					dec.opClass = clsArith;
				else if (funct7 == funct7Sub && funct3 == f3AddSub)
				begin
					dec.opClass = clsArith;
					dec.aluOp = aluSub;
				end
				else if (funct7 == funct7Base && funct3 == f3And)
				begin
					dec.opClass = clsArithNoOvf;	// and cannot overflow
					dec.aluOp = aluAnd;
				end
				else if (funct7 == funct7Base && funct3 == f3Slt)
				begin
					dec.opClass = clsSetLess;
					dec.aluOp = aluCompare;
				end
			end
			opcodeImm:
			begin
				dec.immSel = immI;
				if (funct3 == f3AddSub)
					dec.opClass = (instr[31:7] == '0) ? clsArithNoOvf : clsArith;	// nop
				else if (funct3 == f3Slt)
				begin
					dec.opClass = clsSetLess;
					dec.aluOp = aluCompare;
				end
			end
			opcodeBranch:
			begin
				dec.immSel = immB;
				if (funct3 == f3Beq || funct3 == f3Bne || funct3 == f3Blt || funct3 == f3Bge)
					dec.opClass = clsBranch;
			end
			opcodeLui:
			begin
				dec.opClass = clsLui;
				dec.immSel = immU;
			end
			opcodeLoad:
			begin
				dec.immSel = immI;
				if (funct3 == f3Double)
					dec.opClass = clsLoad;
			end
			opcodeStore:
			begin
				dec.immSel = immS;
				if (funct3 == f3Double)
					dec.opClass = clsStore;
			end
			opcodeJal:
			begin
				dec.opClass = clsJal;
				dec.immSel = immJ;
			end
			opcodeJalr:
			begin
				dec.immSel = immI;
				if (funct3 == f3AddSub)
					dec.opClass = clsJalr;
			end
			opcodeSystem:
			begin
				// ebreak is the only system word accepted
				if (instr[31:20] == 12'd1 && instr[19:7] == '0)
					dec.opClass = clsBreak;
			end
			default:
			begin
				dec.opClass = clsIllegal;
			end
		endcase
	end

endmodule

//--- hw/stateSequencer.sv
`timescale 1ns/1ps

module stateSequencer (
	input logic clk,
	input logic rst_n,
	decodeIf.sequencer dec,
	input logic equal,
	input logic less,
	input logic overflow,
	output ctrlPkg::ctrlStep_e step
);
	import ctrlPkg::*;

	ctrlStep_e nextStep;
	logic branchTaken;

	// ****************************************
	// branch decision
	// ****************************************
	always_comb
	begin
		case (dec.branchCond)
			f3Beq: branchTaken = equal;
			f3Bne: branchTaken = !equal;
			f3Blt: branchTaken = less;
			f3Bge: branchTaken = !less;
			default: branchTaken = 1'b0;	// decoder already flags these
		endcase
	end

	always_ff @(posedge clk or posedge rst_n)
	begin
		if (rst_n)
			step <= stepReset;
		else
			step <= nextStep;
	end

	// ****************************************
	// next step
	// ****************************************
	always_comb
	begin
		nextStep = stepFetch;
		case (step)
			stepReset: nextStep = stepFetch;
			stepFetch: nextStep = overflow ? stepOverflowTrap : stepDispatch;	// pc + 4
			stepDispatch:
			begin
				case (dec.opClass)
					clsArith, clsArithNoOvf, clsLui: nextStep = stepExecute;
					clsSetLess: nextStep = stepSetLess;
					clsBranch: nextStep = overflow ? stepOverflowTrap : stepCompare;
					clsLoad, clsStore: nextStep = stepAddress;
					clsJal: nextStep = overflow ? stepOverflowTrap : stepLinkJump;
					clsJalr: nextStep = overflow ? stepOverflowTrap : stepJalrTarget;
					clsBreak: nextStep = stepHalt;
					default: nextStep = stepIllegalTrap;
				endcase
			end
			stepExecute:
			begin
				if (dec.opClass == clsArith && overflow)
					nextStep = stepOverflowTrap;
				else
					nextStep = stepWriteback;
			end
			stepWriteback: nextStep = stepFetch;
			stepSetLess: nextStep = stepFetch;
			stepCompare: nextStep = branchTaken ? stepTakeBranch : stepFetch;
			stepTakeBranch: nextStep = stepFetch;
			stepAddress:
			begin
				if (overflow)
					nextStep = stepOverflowTrap;	// bad effective address
				else if (dec.opClass == clsLoad)
					nextStep = stepLoadWait;
				else
					nextStep = stepMemWrite;
			end
			stepLoadWait: nextStep = stepLoadWrite;	// memory read latency
			stepLoadWrite: nextStep = stepFetch;
			stepMemWrite: nextStep = stepFetch;
			stepLinkJump: nextStep = stepFetch;
			stepJalrTarget: nextStep = stepJalrJump;
			stepJalrJump: nextStep = stepFetch;
			stepHalt: nextStep = stepHalt;	// only reset leaves
			stepIllegalTrap, stepOverflowTrap: nextStep = stepCauseLoad;
			stepCauseLoad: nextStep = stepTrapJump;
			stepTrapJump: nextStep = stepFetch;
			default: nextStep = stepFetch;
		endcase
	end

	// ****************************************
	// checks
	// ****************************************
	haltIsFinal: assert property (@(posedge clk) disable iff (rst_n)
		step == stepHalt |=> step == stepHalt);

	// worst case is an overflow in address, three trap steps, then fetch
	backToFetch: assert property (@(posedge clk) disable iff (rst_n)
		step != stepHalt |-> ##[1:6] (step == stepFetch || step == stepHalt));

endmodule

//--- hw/controlEncoder.sv
`timescale 1ns/1ps

module controlEncoder (
	input ctrlPkg::ctrlStep_e step,
	decodeIf.encoder dec,
	input logic less,
	output ctrlPkg::aluOp_t aluOp,
	output ctrlPkg::immSel_t immSel,
	output ctrlPkg::muxSel_t srcASel,
	output ctrlPkg::muxSel_t srcBSel,
	output ctrlPkg::muxSel_t wbSel,
	output ctrlPkg::muxSel_t pcSel,
	output ctrlPkg::muxSel_t mem64AddrSel,
	output logic pcWrite,
	output logic instrWrite,
	output logic regAWrite,
	output logic regBWrite,
	output logic aluOutWrite,
	output logic regFileWrite,
	output logic mem64Write,
	output logic mdrWrite,
	output logic epcWrite
);
	import ctrlPkg::*;

	muxSel_t operandB;
	logic pcRelative;

	assign operandB = (dec.immSel == immNone) ? srcBRegB : srcBImm;	// R-type vs immediate
	assign pcRelative = (dec.opClass == clsBranch || dec.opClass == clsJal ||
		dec.opClass == clsJalr);

	always_comb
	begin
		aluOp = '0;
		immSel = immNone;
		srcASel = srcAPc;
		srcBSel = srcBFour;
		wbSel = wbAluOut;
		pcSel = pcAlu;
		mem64AddrSel = mem64AddrAlu;
		pcWrite = 1'b0;
		instrWrite = 1'b0;
		regAWrite = 1'b0;
		regBWrite = 1'b0;
		aluOutWrite = 1'b0;
		regFileWrite = 1'b0;
		mem64Write = 1'b0;
		mdrWrite = 1'b0;
		epcWrite = 1'b0;
		case (step)
			stepFetch:
			begin
				pcWrite = 1'b1;	// pc <= pc + 4
				instrWrite = 1'b1;
				aluOutWrite = 1'b1;
				epcWrite = 1'b1;	// keep pc for a later trap
				aluOp = aluAdd;
				srcASel = srcAPc;
				srcBSel = srcBFour;
				pcSel = pcAlu;
			end
			stepDispatch:
			begin
				regAWrite = 1'b1;
				regBWrite = 1'b1;
				if (pcRelative)
				begin
					// jump target computed ahead of time
					aluOp = aluAdd;
					srcASel = srcAPc;
					srcBSel = srcBImm;
					immSel = dec.immSel;
					aluOutWrite = (dec.opClass != clsJalr);
				end
			end
			stepExecute:
			begin
				aluOp = dec.aluOp;
				srcASel = (dec.opClass == clsLui) ? srcAZero : srcARegA;
				srcBSel = operandB;
				immSel = dec.immSel;
				aluOutWrite = 1'b1;
			end
			stepWriteback:
			begin
				regFileWrite = 1'b1;
				wbSel = wbAluOut;
			end
			stepSetLess:
			begin
				aluOp = aluCompare;
				srcASel = srcARegA;
				srcBSel = operandB;	// slt or slti
				immSel = dec.immSel;
				regFileWrite = 1'b1;
				wbSel = less ? wbLessOne : wbLessZero;
			end
			stepCompare:
			begin
				aluOp = aluCompare;
				srcASel = srcARegA;
				srcBSel = srcBRegB;
			end
			stepTakeBranch, stepJalrJump:
			begin
				pcWrite = 1'b1;
				pcSel = pcAluOut;
			end
			stepAddress:
			begin
				aluOp = aluAdd;	// base + offset
				srcASel = srcARegA;
				srcBSel = srcBImm;
				immSel = dec.immSel;
				aluOutWrite = 1'b1;
			end
			stepLoadWrite:
			begin
				regFileWrite = 1'b1;
				wbSel = wbMem;
			end
			stepMemWrite:
			begin
				mem64Write = 1'b1;
				mem64AddrSel = mem64AddrOut;
			end
			stepLinkJump:
			begin
				pcWrite = 1'b1;
				pcSel = pcAluOut;
				regFileWrite = 1'b1;	// rd <= return address
				wbSel = wbPc;
			end
			stepJalrTarget:
			begin
				regFileWrite = 1'b1;
				wbSel = wbPc;
				aluOp = aluAdd;
				srcASel = srcARegA;
				srcBSel = srcBImm;
				immSel = dec.immSel;
				aluOutWrite = 1'b1;
			end
			stepIllegalTrap: pcSel = pcIllegalVec;
			stepOverflowTrap: pcSel = pcOverflowVec;
			stepCauseLoad: mdrWrite = 1'b1;	// handler address from the vector
			stepTrapJump:
			begin
				pcWrite = 1'b1;
				pcSel = pcCauseVec;
			end
			default:
			begin
				pcSel = pcAlu;	// reset, load wait and halt drive nothing
			end
		endcase
	end

	// ****************************************
	// checks
	// ****************************************
	fetchOnlyLoadsIr: assert property (@(posedge dec.clk)
		(pcWrite && instrWrite) |-> step == stepFetch);

	noMemAndRegWrite: assert property (@(posedge dec.clk)
		!(mem64Write && regFileWrite));

endmodule

//--- hw/ctrlUnit.sv
`timescale 1ns/1ps

module ctrlUnit (
	input logic clk,
	input logic rst_n,
	input ctrlPkg::instr_t instr,
	input logic equal,
	input logic less,
	input logic overflow,
	output ctrlPkg::aluOp_t aluOp,
	output ctrlPkg::immSel_t immSel,
	output ctrlPkg::muxSel_t srcASel,
	output ctrlPkg::muxSel_t srcBSel,
	output ctrlPkg::muxSel_t wbSel,
	output ctrlPkg::muxSel_t pcSel,
	output ctrlPkg::muxSel_t mem64AddrSel,
	output logic pcWrite,
	output logic instrWrite,
	output logic regAWrite,
	output logic regBWrite,
	output logic aluOutWrite,
	output logic regFileWrite,
	output logic mem64Write,
	output logic mdrWrite,
	output logic epcWrite
);
	import ctrlPkg::*;

	ctrlStep_e step;	// current control step

	decodeIf dec (.clk(clk));

	instrDecoder decoder (
		.instr(instr),
		.dec(dec.decoder)
	);

	stateSequencer sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.dec(dec.sequencer),
		.equal(equal),
		.less(less),
		.overflow(overflow),
		.step(step)
	);

	controlEncoder encoder (
		.step(step),
		.dec(dec.encoder),
		.less(less),
		.aluOp(aluOp),
		.immSel(immSel),
		.srcASel(srcASel),
		.srcBSel(srcBSel),
		.wbSel(wbSel),
		.pcSel(pcSel),
		.mem64AddrSel(mem64AddrSel),
		.pcWrite(pcWrite),
		.instrWrite(instrWrite),
		.regAWrite(regAWrite),
		.regBWrite(regBWrite),
		.aluOutWrite(aluOutWrite),
		.regFileWrite(regFileWrite),
		.mem64Write(mem64Write),
		.mdrWrite(mdrWrite),
		.epcWrite(epcWrite)
	);

endmodule

//--- include/ctrlModel.svh
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

// ****************************************
// expected control word
// ****************************************
typedef struct packed {
	aluOp_t aluOp;
	immSel_t immSel;
	muxSel_t srcASel;
	muxSel_t srcBSel;
	muxSel_t wbSel;
	muxSel_t pcSel;
	muxSel_t mem64AddrSel;
	logic pcWrite;
	logic instrWrite;
	logic regAWrite;
	logic regBWrite;
	logic aluOutWrite;
	logic regFileWrite;
	logic mem64Write;
	logic mdrWrite;
	logic epcWrite;
} ctrlWord_t;

// funct3 values straight from the RV base encoding
function automatic logic branchHolds(input funct3_t f3, input logic eq, input logic lt);
	case (f3)
		3'b000: return eq;	// beq
		3'b001: return !eq;	// bne
		3'b100: return lt;	// blt
		3'b101: return !lt;	// bge
		default: return 1'b0;
	endcase
endfunction

function automatic ctrlStep_e nextModelStep(input ctrlStep_e s, input opClass_e c,
		input funct3_t f3, input logic eq, input logic lt, input logic ovf);
	ctrlStep_e n;
	n = stepFetch;	// reset and every final step
	case (s)
		stepFetch: n = ovf ? stepOverflowTrap : stepDispatch;
		stepDispatch:
		begin
			case (c)
				clsArith, clsArithNoOvf, clsLui: n = stepExecute;
				clsSetLess: n = stepSetLess;
				clsBranch: n = ovf ? stepOverflowTrap : stepCompare;
				clsLoad, clsStore: n = stepAddress;
				clsJal: n = ovf ? stepOverflowTrap : stepLinkJump;
				clsJalr: n = ovf ? stepOverflowTrap : stepJalrTarget;
				clsBreak: n = stepHalt;
				default: n = stepIllegalTrap;
			endcase
		end
		stepExecute: n = (c == clsArith && ovf) ? stepOverflowTrap : stepWriteback;
		stepCompare: n = branchHolds(f3, eq, lt) ? stepTakeBranch : stepFetch;
		stepAddress:
		begin
			if (ovf)
				n = stepOverflowTrap;
			else
				n = (c == clsLoad) ? stepLoadWait : stepMemWrite;
		end
		stepLoadWait: n = stepLoadWrite;
		stepJalrTarget: n = stepJalrJump;
		stepHalt: n = stepHalt;	// sticky until reset
		stepIllegalTrap, stepOverflowTrap: n = stepCauseLoad;
		stepCauseLoad: n = stepTrapJump;
		default: n = stepFetch;
	endcase
	return n;
endfunction

// imm is immNone only for R-type words
function automatic ctrlWord_t expectedWord(input ctrlStep_e s, input opClass_e c,
		input aluOp_t op, input immSel_t imm, input logic lt);
	ctrlWord_t w;
	muxSel_t srcB;
	w = '0;
	srcB = (imm == immNone) ? srcBRegB : srcBImm;
	case (s)
		stepFetch:
		begin
			w.pcWrite = 1'b1;
			w.instrWrite = 1'b1;
			w.aluOutWrite = 1'b1;
			w.epcWrite = 1'b1;
			w.aluOp = aluAdd;	// pc + 4
			w.srcASel = srcAPc;
			w.srcBSel = srcBFour;
			w.pcSel = pcAlu;
		end
		stepDispatch:
		begin
			w.regAWrite = 1'b1;
			w.regBWrite = 1'b1;
			if (c == clsBranch || c == clsJal || c == clsJalr)
			begin
				w.aluOp = aluAdd;
				w.srcASel = srcAPc;
				w.srcBSel = srcBImm;
				w.immSel = imm;
				w.aluOutWrite = (c != clsJalr);
			end
		end
		stepExecute:
		begin
			w.aluOp = op;
			w.srcASel = (c == clsLui) ? srcAZero : srcARegA;
			w.srcBSel = srcB;
			w.immSel = imm;
			w.aluOutWrite = 1'b1;
		end
		stepWriteback: w.regFileWrite = 1'b1;
		stepSetLess:
		begin
			w.aluOp = aluCompare;
			w.srcASel = srcARegA;
			w.srcBSel = srcB;
			w.immSel = imm;
			w.regFileWrite = 1'b1;
			w.wbSel = lt ? wbLessOne : wbLessZero;
		end
		stepCompare:
		begin
			w.aluOp = aluCompare;
			w.srcASel = srcARegA;
			w.srcBSel = srcBRegB;
		end
		stepTakeBranch, stepJalrJump:
		begin
			w.pcWrite = 1'b1;
			w.pcSel = pcAluOut;
		end
		stepAddress:
		begin
			w.aluOp = aluAdd;
			w.srcASel = srcARegA;
			w.srcBSel = srcBImm;
			w.immSel = imm;
			w.aluOutWrite = 1'b1;
		end
		stepLoadWrite:
		begin
			w.regFileWrite = 1'b1;
			w.wbSel = wbMem;
		end
		stepMemWrite:
		begin
			w.mem64Write = 1'b1;
			w.mem64AddrSel = mem64AddrOut;
		end
		stepLinkJump:
		begin
			w.pcWrite = 1'b1;
			w.pcSel = pcAluOut;
			w.regFileWrite = 1'b1;
			w.wbSel = wbPc;
		end
		stepJalrTarget:
		begin
			w.regFileWrite = 1'b1;
			w.wbSel = wbPc;
			w.aluOp = aluAdd;
			w.srcASel = srcARegA;
			w.srcBSel = srcBImm;
			w.immSel = imm;
			w.aluOutWrite = 1'b1;
		end
		stepIllegalTrap: w.pcSel = pcIllegalVec;
		stepOverflowTrap: w.pcSel = pcOverflowVec;
		stepCauseLoad: w.mdrWrite = 1'b1;
		stepTrapJump:
		begin
			w.pcWrite = 1'b1;
			w.pcSel = pcCauseVec;
		end
		default: w = '0;	// reset, load wait, halt
	endcase
	return w;
endfunction

`endif

//--- tests/ctrlUnitTb.sv
`timescale 1ns/1ps

module ctrlUnitTb;
	import ctrlPkg::*;

	`include "ctrlModel.svh"

	localparam int instrTotal = 400;
	localparam int timeoutLimit = 3000;	// 400 instructions, 6 cycles worst case, plus margin
	localparam int haltCycles = 20;

	logic clk;
	logic rst_n;
	instr_t instr;
	logic equal;
	logic less;
	logic overflow;
	aluOp_t aluOp;
	immSel_t immSel;
	muxSel_t srcASel;
	muxSel_t srcBSel;
	muxSel_t wbSel;
	muxSel_t pcSel;
	muxSel_t mem64AddrSel;
	logic pcWrite;
	logic instrWrite;
	logic regAWrite;
	logic regBWrite;
	logic aluOutWrite;
	logic regFileWrite;
	logic mem64Write;
	logic mdrWrite;
	logic epcWrite;

	// model state
	ctrlStep_e modelStep;
	ctrlStep_e prevStep;
	opClass_e curCls;	// class of the word in the IR
	aluOp_t curOp;
	immSel_t curImm;
	funct3_t curF3;
	instr_t nextWord;
	ctrlWord_t want;
	int cycle;
	int fetched;
	int haltSeen;
	int sinceFetch;
	logic haveFetch;
	logic trapSeen;
	logic tookBranch;

	ctrlUnit UUT (.*);

	always #50 clk = ~clk;

	// ****************************************
	// helpers
	// ****************************************
	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("FAIL at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
			$display("STATUS: FAIL");
			$fatal(1, "output mismatch");
		end
	endtask

	// fetch-to-fetch lengths of the control sequence
	function automatic int intervalFor(input opClass_e c, input logic taken);
		case (c)
			clsArith, clsArithNoOvf, clsLui: return 4;
			clsSetLess: return 3;
			clsBranch: return taken ? 4 : 3;
			clsLoad: return 5;
			clsStore: return 4;
			clsJal: return 3;
			clsJalr: return 4;
			clsIllegal: return 5;	// dispatch, trap, cause, jump
			default: return 0;
		endcase
	endfunction

	task automatic pickInstruction(input logic last);
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [11:0] imm12;
		logic [19:0] imm20;
		int unsigned kind;
		rd = 5'($urandom);
		rs1 = 5'($urandom);
		rs2 = 5'($urandom);
		imm12 = 12'($urandom);
		imm20 = 20'($urandom);
		kind = (($urandom % 100) < 3) ? 99 : $urandom % 16;
		curOp = aluAdd;
		curF3 = 3'b000;
		if (last)
			kind = 100;
		case (kind)
			0, 1, 2, 3:
			begin
				curImm = immNone;
				curCls = clsArith;
				case (kind)
					0: nextWord = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
					1:
					begin
						nextWord = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
						curOp = aluSub;
					end
					2:
					begin
						nextWord = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
						curOp = aluAnd;
						curCls = clsArithNoOvf;
					end
					default:
					begin
						nextWord = {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
						curOp = aluCompare;
						curCls = clsSetLess;
					end
				endcase
			end
			4:
			begin
				nextWord = {imm12, rs1, 3'b000, rd, 7'b0010011};
				// addi x0, x0, 0 is the nop
				curCls = (imm12 == 12'd0 && rs1 == 5'd0 && rd == 5'd0) ?
					clsArithNoOvf : clsArith;
				curImm = immI;
			end
			5:
			begin
				nextWord = 32'h0000_0013;	// nop
				curCls = clsArithNoOvf;
				curImm = immI;
			end
			6:
			begin
				nextWord = {imm12, rs1, 3'b010, rd, 7'b0010011};
				curCls = clsSetLess;
				curOp = aluCompare;
				curImm = immI;
			end
			7, 8, 9, 10:
			begin
				curF3 = (kind == 7) ? 3'b000 : (kind == 8) ? 3'b001 :
					(kind == 9) ? 3'b100 : 3'b101;
				nextWord = {imm12[11:5], rs2, rs1, curF3, imm12[4:0], 7'b1100011};
				curCls = clsBranch;
				curImm = immB;
			end
			11:
			begin
				nextWord = {imm20, rd, 7'b0110111};
				curCls = clsLui;
				curImm = immU;
			end
			12:
			begin
				nextWord = {imm12, rs1, 3'b011, rd, 7'b0000011};	// ld
				curCls = clsLoad;
				curImm = immI;
			end
			13:
			begin
				nextWord = {imm12[11:5], rs2, rs1, 3'b011, imm12[4:0], 7'b0100011};	// sd
				curCls = clsStore;
				curImm = immS;
			end
			14:
			begin
				nextWord = {imm20, rd, 7'b1101111};
				curCls = clsJal;
				curImm = immJ;
			end
			15:
			begin
				nextWord = {imm12, rs1, 3'b000, rd, 7'b1100111};
				curCls = clsJalr;
				curImm = immI;
			end
			100:
			begin
				nextWord = 32'h0010_0073;	// ebreak
				curCls = clsBreak;
				curImm = immNone;
			end
			default:
			begin
				// unused opcode, lw, slli
				case ($urandom % 3)
					0: nextWord = {imm20, rd, 7'b1111111};
					1: nextWord = {imm12, rs1, 3'b010, rd, 7'b0000011};
					default: nextWord = {imm12, rs1, 3'b001, rd, 7'b0010011};
				endcase
				curCls = clsIllegal;
				curImm = immNone;
			end
		endcase
	endtask

	task automatic checkCycle();
		want = expectedWord(modelStep, curCls, curOp, curImm, less);
		checkValue("aluOp", 32'(aluOp), 32'(want.aluOp));
		checkValue("immSel", 32'(immSel), 32'(want.immSel));
		checkValue("srcASel", 32'(srcASel), 32'(want.srcASel));
		checkValue("srcBSel", 32'(srcBSel), 32'(want.srcBSel));
		checkValue("wbSel", 32'(wbSel), 32'(want.wbSel));
		checkValue("pcSel", 32'(pcSel), 32'(want.pcSel));
		checkValue("mem64AddrSel", 32'(mem64AddrSel), 32'(want.mem64AddrSel));
		checkValue("pcWrite", 32'(pcWrite), 32'(want.pcWrite));
		checkValue("instrWrite", 32'(instrWrite), 32'(want.instrWrite));
		checkValue("regAWrite", 32'(regAWrite), 32'(want.regAWrite));
		checkValue("regBWrite", 32'(regBWrite), 32'(want.regBWrite));
		checkValue("aluOutWrite", 32'(aluOutWrite), 32'(want.aluOutWrite));
		checkValue("regFileWrite", 32'(regFileWrite), 32'(want.regFileWrite));
		checkValue("mem64Write", 32'(mem64Write), 32'(want.mem64Write));
		checkValue("mdrWrite", 32'(mdrWrite), 32'(want.mdrWrite));
		checkValue("epcWrite", 32'(epcWrite), 32'(want.epcWrite));
		sinceFetch++;
		if (modelStep == stepOverflowTrap)
			trapSeen = 1'b1;	// trapped instructions have no fixed length
		if (modelStep == stepTakeBranch)
			tookBranch = 1'b1;
		if (instrWrite)
		begin
			if (haveFetch && !trapSeen)
				checkValue("fetch interval", 32'(sinceFetch), 32'(intervalFor(curCls, tookBranch)));
			haveFetch = 1'b1;
			sinceFetch = 0;
			trapSeen = 1'b0;
			tookBranch = 1'b0;
		end
		if (modelStep == stepHalt)
			haltSeen++;
	endtask

	// ****************************************
	// stimulus and model
	// ****************************************
	initial
	begin
		clk = 1'b0;
		rst_n = 1'b1;
		instr = 32'h0000_0013;
		equal = 1'b0;
		less = 1'b0;
		overflow = 1'b0;
		modelStep = stepReset;
		curCls = clsArithNoOvf;
		curOp = aluAdd;
		curImm = immI;
		curF3 = 3'b000;
		cycle = 0;
		fetched = 0;
		haltSeen = 0;
		sinceFetch = 0;
		haveFetch = 1'b0;
		trapSeen = 1'b0;
		tookBranch = 1'b0;
	end

	always @(posedge clk)
	begin
		cycle++;
		if (cycle == 1)
			void'($urandom(32'h4ed0_8a71));
		if (cycle > timeoutLimit)
		begin
			$display("timeout: the control unit did not halt within %0d cycles", timeoutLimit);
			$display("STATUS: FAIL");
			$fatal(1, "run did not finish");
		end
		prevStep = modelStep;
		if (rst_n)
			modelStep = stepReset;
		else
			modelStep = nextModelStep(prevStep, curCls, curF3, equal, less, overflow);
		if (prevStep == stepFetch)
		begin
			fetched++;	// IR is loaded at the end of fetch
			pickInstruction(fetched >= instrTotal);
			instr <= nextWord;
		end
		rst_n <= (cycle < 5);
		equal <= (($urandom % 2) == 1);
		less <= (($urandom % 2) == 1);
		overflow <= (($urandom % 100) < 5);
	end

	always @(negedge clk)
	begin
		if (cycle > 0)
			checkCycle();
		if (haltSeen >= haltCycles)
		begin
			$display("halted after %0d fetches, %0d cycles", fetched, cycle);
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

//--- ctrlUnit.f
+incdir+include
hw/ctrlPkg.sv
hw/decodeIf.sv
hw/instrDecoder.sv
hw/stateSequencer.sv
hw/controlEncoder.sv
hw/ctrlUnit.sv
tests/ctrlUnitTb.sv

//--- Makefile
TOP = ctrlUnitTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check for a pass"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert -f ctrlUnit.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
